/* design/tlb_pkg.sv */
package tlb_pkg;

    // page sizes supported by this TLB, as log2 of the page size
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_2M = 6'd21;

    // access type reported in direct address mode
    localparam logic [1:0] DA_MAT = 2'b01;

    // ad_mode[0] set means direct mode, any other value is paged mode

    // one half of an even/odd page pair
    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    // one TLB entry, p0 maps the even page and p1 the odd page
    typedef struct packed {
        logic [18:0] vppn;
        logic [9:0]  asid;
        logic [5:0]  ps;
        logic        g;
        logic        e;
        tlb_page_t   p0;
        tlb_page_t   p1;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        MEM_FETCH = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_t;

    // one-hot exception vector, at most one bit set per lookup
    typedef logic [5:0] tlb_exc_t;

    localparam int EXC_TLBR = 0;
    localparam int EXC_PIF  = 1;
    localparam int EXC_PIL  = 2;
    localparam int EXC_PIS  = 3;
    localparam int EXC_PME  = 4;
    localparam int EXC_PPI  = 5;

endpackage

/* design/tlb_hit_if.sv */
`timescale 1ns/100ps

// lookup result of one search port, selected page of the hit entry
interface tlb_hit_if;
    logic        hit;
    logic [19:0] pfn;
    logic [5:0]  ps;
    logic [1:0]  mat;
    logic [1:0]  plv;
    logic        v;
    logic        d;
    // vaddr bit ps of the lookup, picks the odd half
    logic        odd;

    modport match (
        output hit, pfn, ps, mat, plv, v, d, odd
    );

    modport translate (
        input hit, pfn, ps, mat, plv, v, d, odd
    );

endinterface

/* design/tlb_storage.sv */
`timescale 1ns/100ps

module tlb_storage #(
    parameter int TLBNUM = 16
) (
    input  logic                        clk,
    input  logic                        rst,

    // write and refill port
    input  logic                        we,
    input  logic                        fill_mode,
    input  logic [$clog2(TLBNUM)-1:0]   w_index,
    input  logic [$clog2(TLBNUM)-1:0]   f_index,
    input  tlb_pkg::tlb_entry_t         w_entry,

    // tlbrd-style read port
    input  logic [$clog2(TLBNUM)-1:0]   r_index,
    output tlb_pkg::tlb_entry_t         r_entry,

    // whole array for the comparators
    output tlb_pkg::tlb_entry_t         entries [TLBNUM]
);

    logic [$clog2(TLBNUM)-1:0] wr_index;

    // refill takes its index from the refill counter
    assign wr_index = fill_mode ? f_index : w_index;

    // reset invalidates every entry
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLBNUM; i++) begin
                entries[i].e <= 1'b0;
            end
        end else if (we) begin
            entries[wr_index] <= w_entry;
        end
    end

    assign r_entry = entries[r_index];

    // match logic only decodes the two supported page sizes
    a_write_ps : assert property (
        @(posedge clk) disable iff (rst)
        we |-> (w_entry.ps == tlb_pkg::PS_4K || w_entry.ps == tlb_pkg::PS_2M)
    ) else $error("tlb_storage: write with unsupported ps %0d", w_entry.ps);

endmodule

/* design/tlb_match.sv */
`timescale 1ns/100ps

module tlb_match #(
    parameter int TLBNUM = 16
) (
    input  tlb_pkg::tlb_entry_t         entries [TLBNUM],
    input  logic [31:0]                 vaddr,
    input  logic [9:0]                  asid,
    output logic [$clog2(TLBNUM)-1:0]   hit_index,
    tlb_hit_if.match                    hit
);

    localparam int IDX_W = $clog2(TLBNUM);

    logic [TLBNUM-1:0] match_vec;
    logic [TLBNUM-1:0] odd_vec;

    // per-entry compare
    always_comb begin
        for (int i = 0; i < TLBNUM; i++) begin
            // low vppn bits fall inside a 2M page
            match_vec[i] = entries[i].e
                && (entries[i].g || entries[i].asid == asid)
                && entries[i].vppn[18:9] == vaddr[31:22]
                && (entries[i].ps == tlb_pkg::PS_2M
                    || entries[i].vppn[8:0] == vaddr[21:13]);
            // vaddr bit ps picks the odd half
            odd_vec[i] = (entries[i].ps == tlb_pkg::PS_2M) ? vaddr[21] : vaddr[12];
        end
    end

    // or-select the hit entry, match_vec is one-hot or zero
    always_comb begin
        tlb_pkg::tlb_page_t page_sel;
        logic [5:0]         ps_sel;
        logic               odd_sel;
        logic [IDX_W-1:0]   idx_sel;

        page_sel = '0;
        ps_sel   = '0;
        odd_sel  = 1'b0;
        idx_sel  = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            if (match_vec[i]) begin
                page_sel = page_sel | (odd_vec[i] ? entries[i].p1 : entries[i].p0);
                ps_sel   = ps_sel | entries[i].ps;
                odd_sel  = odd_sel | odd_vec[i];
                idx_sel  = idx_sel | IDX_W'(i);
            end
        end

        hit.hit   = |match_vec;
        hit.pfn   = page_sel.pfn;
        hit.ps    = ps_sel;
        hit.mat   = page_sel.mat;
        hit.plv   = page_sel.plv;
        hit.v     = page_sel.v;
        hit.d     = page_sel.d;
        hit.odd   = odd_sel;
        hit_index = idx_sel;
    end

    // two hits would merge two entries into garbage
    always_comb begin
        if (!$isunknown(match_vec)) begin
            assert ($onehot0(match_vec))
            else $error("tlb_match: more than one entry hits, vector %b", match_vec);
        end
    end

endmodule

/* design/tlb_translate.sv */
`timescale 1ns/100ps

module tlb_translate (
    input  logic                clk,
    input  logic                rst,

    // request captured on en
    input  logic                en,
    input  logic [1:0]          ad_mode,
    input  logic [31:0]         vaddr,
    input  logic [1:0]          plv,
    input  tlb_pkg::mem_type_t  mem_type,
    tlb_hit_if.translate        hit,

    // result valid from the edge after en
    output logic [31:0]         paddr,
    output logic [1:0]          mat,
    output tlb_pkg::tlb_exc_t   exception
);

    logic               valid_q;
    logic               direct_q;
    logic [31:0]        vaddr_q;
    logic [1:0]         plv_q;
    tlb_pkg::mem_type_t mem_type_q;
    logic               hit_q;
    logic [19:0]        pfn_q;
    logic [5:0]         ps_q;
    logic [1:0]         mat_q;
    logic [1:0]         page_plv_q;
    logic               v_q;
    logic               d_q;

    // output register so the outputs read zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q    <= 1'b0;
            direct_q   <= 1'b0;
            vaddr_q    <= '0;
            plv_q      <= '0;
            mem_type_q <= tlb_pkg::MEM_FETCH;
            hit_q      <= 1'b0;
            pfn_q      <= '0;
            ps_q       <= '0;
            mat_q      <= '0;
            page_plv_q <= '0;
            v_q        <= 1'b0;
            d_q        <= 1'b0;
        end else if (en) begin
            valid_q    <= 1'b1;
            direct_q   <= ad_mode[0];
            vaddr_q    <= vaddr;
            plv_q      <= plv;
            mem_type_q <= mem_type;
            hit_q      <= hit.hit;
            pfn_q      <= hit.pfn;
            ps_q       <= hit.ps;
            mat_q      <= hit.mat;
            page_plv_q <= hit.plv;
            v_q        <= hit.v;
            d_q        <= hit.d;
        end
    end

    // offset width of the physical address follows the page size
    always_comb begin
        if (direct_q) begin
            paddr = vaddr_q;
        end else if (ps_q == tlb_pkg::PS_2M) begin
            paddr = {pfn_q[19:9], vaddr_q[20:0]};
        end else begin
            paddr = {pfn_q, vaddr_q[11:0]};
        end
    end

    assign mat = direct_q ? tlb_pkg::DA_MAT : mat_q;

    // priority is miss, invalid page, privilege, then dirty
    always_comb begin
        exception = '0;
        if (valid_q && !direct_q) begin
            if (!hit_q) begin
                exception[tlb_pkg::EXC_TLBR] = 1'b1;
            end else if (!v_q) begin
                case (mem_type_q)
                    tlb_pkg::MEM_FETCH: exception[tlb_pkg::EXC_PIF] = 1'b1;
                    tlb_pkg::MEM_LOAD:  exception[tlb_pkg::EXC_PIL] = 1'b1;
                    default:            exception[tlb_pkg::EXC_PIS] = 1'b1;
                endcase
            end else if (plv_q > page_plv_q) begin
                exception[tlb_pkg::EXC_PPI] = 1'b1;
            end else if (mem_type_q == tlb_pkg::MEM_STORE && !d_q) begin
                exception[tlb_pkg::EXC_PME] = 1'b1;
            end
        end
    end

    a_exc_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(exception)
    ) else $error("tlb_translate: exception not one-hot, %b", exception);

endmodule

/* design/tlb.sv */
`timescale 1ns/100ps

module tlb #(
    parameter int TLBNUM = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [1:0]                  ad_mode,

    // search port 0, instruction fetch
    input  logic [31:0]                 s0_vaddr,
    input  logic [9:0]                  s0_asid,
    input  logic [1:0]                  s0_plv,
    input  tlb_pkg::mem_type_t          s0_mem_type,
    input  logic                        s0_en,
    output logic [31:0]                 s0_paddr,
    output tlb_pkg::tlb_exc_t           s0_exception,
    output logic [1:0]                  s0_mat,

    // search port 1, data
    input  logic [31:0]                 s1_vaddr,
    input  logic [9:0]                  s1_asid,
    input  logic [1:0]                  s1_plv,
    input  tlb_pkg::mem_type_t          s1_mem_type,
    input  logic                        s1_en,
    output logic [31:0]                 s1_paddr,
    output tlb_pkg::tlb_exc_t           s1_exception,
    output logic [1:0]                  s1_mat,

    // write and refill port
    input  logic                        we,
    input  logic                        fill_mode,
    input  logic [$clog2(TLBNUM)-1:0]   w_index,
    input  logic [$clog2(TLBNUM)-1:0]   f_index,
    input  logic [18:0]                 w_vppn,
    input  logic [9:0]                  w_asid,
    input  logic [5:0]                  w_ps,
    input  logic                        w_e,
    input  logic                        w_g,
    input  logic [19:0]                 w_pfn0,
    input  logic [1:0]                  w_mat0,
    input  logic [1:0]                  w_plv0,
    input  logic                        w_d0,
    input  logic                        w_v0,
    input  logic [19:0]                 w_pfn1,
    input  logic [1:0]                  w_mat1,
    input  logic [1:0]                  w_plv1,
    input  logic                        w_d1,
    input  logic                        w_v1,

    // read port
    input  logic [$clog2(TLBNUM)-1:0]   r_index,
    output logic [18:0]                 r_vppn,
    output logic [9:0]                  r_asid,
    output logic [5:0]                  r_ps,
    output logic                        r_e,
    output logic                        r_g,
    output logic [19:0]                 r_pfn0,
    output logic [1:0]                  r_mat0,
    output logic [1:0]                  r_plv0,
    output logic                        r_d0,
    output logic                        r_v0,
    output logic [19:0]                 r_pfn1,
    output logic [1:0]                  r_mat1,
    output logic [1:0]                  r_plv1,
    output logic                        r_d1,
    output logic                        r_v1,

    // software search, like tlbsrch
    input  logic [18:0]                 s_vppn,
    input  logic [9:0]                  s_asid,
    input  logic                        check_mode,
    output logic [$clog2(TLBNUM)-1:0]   s_index,
    output logic                        rs_e
);

    tlb_pkg::tlb_entry_t entries [TLBNUM];
    tlb_pkg::tlb_entry_t w_entry;
    tlb_pkg::tlb_entry_t r_entry;

    tlb_hit_if hit0 ();
    tlb_hit_if hit1 ();
    // page outputs of the software search are not needed
    tlb_hit_if hit_s ();

    assign w_entry = '{
        vppn: w_vppn,
        asid: w_asid,
        ps:   w_ps,
        g:    w_g,
        e:    w_e,
        p0:   '{pfn: w_pfn0, mat: w_mat0, plv: w_plv0, d: w_d0, v: w_v0},
        p1:   '{pfn: w_pfn1, mat: w_mat1, plv: w_plv1, d: w_d1, v: w_v1}
    };

    tlb_storage #(.TLBNUM(TLBNUM)) u_storage (
        .clk       (clk),
        .rst       (rst),
        .we        (we),
        .fill_mode (fill_mode),
        .w_index   (w_index),
        .f_index   (f_index),
        .w_entry   (w_entry),
        .r_index   (r_index),
        .r_entry   (r_entry),
        .entries   (entries)
    );

    tlb_match #(.TLBNUM(TLBNUM)) u_match0 (
        .entries   (entries),
        .vaddr     (s0_vaddr),
        .asid      (s0_asid),
        .hit_index (),
        .hit       (hit0)
    );

    tlb_match #(.TLBNUM(TLBNUM)) u_match1 (
        .entries   (entries),
        .vaddr     (s1_vaddr),
        .asid      (s1_asid),
        .hit_index (),
        .hit       (hit1)
    );

    // vppn placed at bits 31:13 so the 2M compare rule applies unchanged
    tlb_match #(.TLBNUM(TLBNUM)) u_match_s (
        .entries   (entries),
        .vaddr     ({s_vppn, 13'b0}),
        .asid      (s_asid),
        .hit_index (s_index),
        .hit       (hit_s)
    );

    tlb_translate u_translate0 (
        .clk       (clk),
        .rst       (rst),
        .en        (s0_en),
        .ad_mode   (ad_mode),
        .vaddr     (s0_vaddr),
        .plv       (s0_plv),
        .mem_type  (s0_mem_type),
        .hit       (hit0),
        .paddr     (s0_paddr),
        .mat       (s0_mat),
        .exception (s0_exception)
    );

    tlb_translate u_translate1 (
        .clk       (clk),
        .rst       (rst),
        .en        (s1_en),
        .ad_mode   (ad_mode),
        .vaddr     (s1_vaddr),
        .plv       (s1_plv),
        .mem_type  (s1_mem_type),
        .hit       (hit1),
        .paddr     (s1_paddr),
        .mat       (s1_mat),
        .exception (s1_exception)
    );

    // read entry fields
    assign r_vppn = r_entry.vppn;
    assign r_asid = r_entry.asid;
    assign r_ps   = r_entry.ps;
    assign r_e    = r_entry.e;
    assign r_g    = r_entry.g;
    assign r_pfn0 = r_entry.p0.pfn;
    assign r_mat0 = r_entry.p0.mat;
    assign r_plv0 = r_entry.p0.plv;
    assign r_d0   = r_entry.p0.d;
    assign r_v0   = r_entry.p0.v;
    assign r_pfn1 = r_entry.p1.pfn;
    assign r_mat1 = r_entry.p1.mat;
    assign r_plv1 = r_entry.p1.plv;
    assign r_d1   = r_entry.p1.d;
    assign r_v1   = r_entry.p1.v;

    assign rs_e = check_mode ? hit_s.hit : r_entry.e;

endmodule

/* bench/tlb_tb.sv */
`timescale 1ns/100ps

module tlb_tb;

    localparam int TLBNUM = 16;
    localparam int IDX_W = $clog2(TLBNUM);
    localparam int N_RAND = 200;
    // reset read, writes (two cycles each), read back and search walk the array
    localparam int STIM_CYCLES = 4 + 5 * TLBNUM + N_RAND + 60;
    localparam int MAX_CYCLES = 2 * STIM_CYCLES + 100;

    // paddr and mat only have a defined value on a hit or in direct mode
    typedef struct packed {
        logic              chk;
        logic [31:0]       paddr;
        logic [1:0]        mat;
        tlb_pkg::tlb_exc_t exc;
    } result_t;

    logic clk;
    logic rst;
    logic [1:0] ad_mode;
    logic [31:0] s0_vaddr, s1_vaddr, s0_paddr, s1_paddr;
    logic [9:0] s0_asid, s1_asid;
    logic [1:0] s0_plv, s1_plv, s0_mat, s1_mat;
    tlb_pkg::mem_type_t s0_mem_type, s1_mem_type;
    logic s0_en, s1_en;
    tlb_pkg::tlb_exc_t s0_exception, s1_exception;
    logic we, fill_mode, check_mode, rs_e;
    logic [IDX_W-1:0] w_index, f_index, r_index, s_index;
    logic [18:0] s_vppn;
    logic [9:0] s_asid;
    tlb_pkg::tlb_entry_t w_ent;
    wire tlb_pkg::tlb_entry_t r_ent;

    // reference state
    tlb_pkg::tlb_entry_t shadow [TLBNUM];
    logic [TLBNUM-1:0] written;
    result_t exp0, exp1;
    logic srch_hit;
    logic [IDX_W-1:0] srch_idx;

    logic [31:0] rng_state = 32'h1246;
    int errors = 0;
    int strobes = 0;
    string test_name = "reset";

    tlb #(.TLBNUM(TLBNUM)) UUT (
        .*,
        .w_vppn (w_ent.vppn),    .w_asid (w_ent.asid),    .w_ps   (w_ent.ps),
        .w_e    (w_ent.e),       .w_g    (w_ent.g),
        .w_pfn0 (w_ent.p0.pfn),  .w_mat0 (w_ent.p0.mat),  .w_plv0 (w_ent.p0.plv),
        .w_d0   (w_ent.p0.d),    .w_v0   (w_ent.p0.v),
        .w_pfn1 (w_ent.p1.pfn),  .w_mat1 (w_ent.p1.mat),  .w_plv1 (w_ent.p1.plv),
        .w_d1   (w_ent.p1.d),    .w_v1   (w_ent.p1.v),
        .r_vppn (r_ent.vppn),    .r_asid (r_ent.asid),    .r_ps   (r_ent.ps),
        .r_e    (r_ent.e),       .r_g    (r_ent.g),
        .r_pfn0 (r_ent.p0.pfn),  .r_mat0 (r_ent.p0.mat),  .r_plv0 (r_ent.p0.plv),
        .r_d0   (r_ent.p0.d),    .r_v0   (r_ent.p0.v),
        .r_pfn1 (r_ent.p1.pfn),  .r_mat1 (r_ent.p1.mat),  .r_plv1 (r_ent.p1.plv),
        .r_d1   (r_ent.p1.d),    .r_v1   (r_ent.p1.v)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // 2M pages ignore the nine low vppn bits
    function automatic logic entry_hits(tlb_pkg::tlb_entry_t ent, logic [18:0] vppn,
                                        logic [9:0] asid);
        logic [18:0] care;
        care = (ent.ps == tlb_pkg::PS_2M) ? 19'h7fe00 : 19'h7ffff;
        return ent.e && (ent.g || ent.asid == asid) && ((ent.vppn & care) == (vppn & care));
    endfunction

    function automatic result_t translate_ref(logic [1:0] mode, logic [31:0] va,
                                              logic [9:0] asid, logic [1:0] plv,
                                              tlb_pkg::mem_type_t mt);
        result_t res;
        tlb_pkg::tlb_page_t pg;
        logic found;
        logic [31:0] mask;
        res = '0;
        pg = '0;
        found = 1'b0;
        mask = '0;
        if (mode[0]) begin
            res.chk = 1'b1;
            res.paddr = va;
            res.mat = tlb_pkg::DA_MAT;
            return res;
        end
        for (int k = 0; k < TLBNUM; k++) begin
            if (entry_hits(shadow[k], va[31:13], asid)) begin
                found = 1'b1;
                mask = (32'd1 << shadow[k].ps) - 32'd1;
                pg = va[shadow[k].ps] ? shadow[k].p1 : shadow[k].p0;
            end
        end
        if (!found) begin
            res.exc[tlb_pkg::EXC_TLBR] = 1'b1;
            return res;
        end
        res.chk = 1'b1;
        res.paddr = ({pg.pfn, 12'h000} & ~mask) | (va & mask);
        res.mat = pg.mat;
        if (!pg.v) begin
            if (mt == tlb_pkg::MEM_FETCH) res.exc[tlb_pkg::EXC_PIF] = 1'b1;
            else if (mt == tlb_pkg::MEM_LOAD) res.exc[tlb_pkg::EXC_PIL] = 1'b1;
            else res.exc[tlb_pkg::EXC_PIS] = 1'b1;
        end else if (plv > pg.plv) begin
            res.exc[tlb_pkg::EXC_PPI] = 1'b1;
        end else if (mt == tlb_pkg::MEM_STORE && !pg.d) begin
            res.exc[tlb_pkg::EXC_PME] = 1'b1;
        end
        return res;
    endfunction

    // shadow copy follows every write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < TLBNUM; k++) begin
                shadow[k].e <= 1'b0;
            end
            written <= '0;
        end else if (we) begin
            shadow[fill_mode ? f_index : w_index] <= w_ent;
            written[fill_mode ? f_index : w_index] <= 1'b1;
        end
    end

    // expected result registered like the output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            exp0 <= '0;
            exp1 <= '0;
        end else begin
            if (s0_en) exp0 <= translate_ref(ad_mode, s0_vaddr, s0_asid, s0_plv, s0_mem_type);
            if (s1_en) exp1 <= translate_ref(ad_mode, s1_vaddr, s1_asid, s1_plv, s1_mem_type);
        end
    end

    always_comb begin
        srch_hit = 1'b0;
        srch_idx = '0;
        for (int k = 0; k < TLBNUM; k++) begin
            if (entry_hits(shadow[k], s_vppn, s_asid)) begin
                srch_hit = 1'b1;
                srch_idx = IDX_W'(k);
            end
        end
    end

    // results are checked on every edge and so also while held
    a_s0_paddr : assert property (@(posedge clk) disable iff (rst)
        !exp0.chk || s0_paddr == exp0.paddr) else begin
        errors++;
        $display("FAILED %s: s0_paddr expected %h, actual %h", test_name, exp0.paddr, s0_paddr);
    end
    a_s1_paddr : assert property (@(posedge clk) disable iff (rst)
        !exp1.chk || s1_paddr == exp1.paddr) else begin
        errors++;
        $display("FAILED %s: s1_paddr expected %h, actual %h", test_name, exp1.paddr, s1_paddr);
    end
    a_s0_mat : assert property (@(posedge clk) disable iff (rst)
        !exp0.chk || s0_mat == exp0.mat) else begin
        errors++;
        $display("FAILED %s: s0_mat expected %h, actual %h", test_name, exp0.mat, s0_mat);
    end
    a_s1_mat : assert property (@(posedge clk) disable iff (rst)
        !exp1.chk || s1_mat == exp1.mat) else begin
        errors++;
        $display("FAILED %s: s1_mat expected %h, actual %h", test_name, exp1.mat, s1_mat);
    end
    a_s0_exc : assert property (@(posedge clk) disable iff (rst)
        s0_exception == exp0.exc) else begin
        errors++;
        $display("FAILED %s: s0_exception expected %b, actual %b",
                 test_name, exp0.exc, s0_exception);
    end
    a_s1_exc : assert property (@(posedge clk) disable iff (rst)
        s1_exception == exp1.exc) else begin
        errors++;
        $display("FAILED %s: s1_exception expected %b, actual %b",
                 test_name, exp1.exc, s1_exception);
    end
    // unwritten entries only have a defined e bit
    a_read : assert property (@(posedge clk) disable iff (rst)
        written[r_index] ? (r_ent == shadow[r_index]) : (r_ent.e == 1'b0)) else begin
        errors++;
        $display("FAILED %s: entry %0d expected %h, actual %h",
                 test_name, r_index, shadow[r_index], r_ent);
    end
    a_rs_e : assert property (@(posedge clk) disable iff (rst)
        rs_e == (check_mode ? srch_hit : shadow[r_index].e)) else begin
        errors++;
        $display("FAILED %s: rs_e expected %b, actual %b", test_name,
                 check_mode ? srch_hit : shadow[r_index].e, rs_e);
    end
    a_s_index : assert property (@(posedge clk) disable iff (rst)
        !srch_hit || s_index == srch_idx) else begin
        errors++;
        $display("FAILED %s: s_index expected %0d, actual %0d", test_name, srch_idx, s_index);
    end

    // high vppn bits carry the index so no two entries overlap
    function automatic tlb_pkg::tlb_entry_t make_entry(int i);
        tlb_pkg::tlb_entry_t ent;
        logic [31:0] r;
        r = next_random();
        ent.vppn = {r[3:0], 6'(i), r[12:4]};
        ent.asid = r[22:13];
        ent.ps = r[23] ? tlb_pkg::PS_2M : tlb_pkg::PS_4K;
        ent.g = (r[25:24] == 2'b00);
        ent.e = 1'b1;
        r = next_random();
        ent.p0 = r[25:0];
        r = next_random();
        ent.p1 = r[25:0];
        return ent;
    endfunction

    task automatic write_entry(input int idx, input tlb_pkg::tlb_entry_t ent,
                               input logic use_fill);
        @(negedge clk);
        we = 1'b1;
        fill_mode = use_fill;
        w_ent = ent;
        // the other index points elsewhere
        w_index = use_fill ? IDX_W'(idx + 1) : IDX_W'(idx);
        f_index = use_fill ? IDX_W'(idx) : IDX_W'(idx + 1);
        @(negedge clk);
        we = 1'b0;
    endtask

    task automatic set_lookup(input int port, input logic en, input logic [31:0] va,
                              input logic [9:0] asid, input logic [1:0] plv,
                              input tlb_pkg::mem_type_t mt);
        if (port == 0) begin
            s0_en = en;
            s0_vaddr = va;
            s0_asid = asid;
            s0_plv = plv;
            s0_mem_type = mt;
        end else begin
            s1_en = en;
            s1_vaddr = va;
            s1_asid = asid;
            s1_plv = plv;
            s1_mem_type = mt;
        end
        if (en) strobes++;
    endtask

    task automatic single_lookup(input int port, input logic [31:0] va,
                                 input logic [9:0] asid, input logic [1:0] plv,
                                 input tlb_pkg::mem_type_t mt);
        @(negedge clk);
        s0_en = 1'b0;
        s1_en = 1'b0;
        set_lookup(port, 1'b1, va, asid, plv, mt);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            s0_en = 1'b0;
            s1_en = 1'b0;
        end
    endtask

    // mostly hits on a written entry and some misses by vppn or asid
    task automatic random_lookup(output logic [31:0] va, output logic [9:0] asid);
        logic [31:0] r;
        int j;
        r = next_random();
        j = int'(r[7:0]) % TLBNUM;
        va = next_random();
        asid = shadow[j].g ? r[24:15] : shadow[j].asid;
        if (r[10:8] == 3'd0) begin
            va[31:22] = {r[14:11], 6'(TLBNUM + j)};
        end else begin
            va[31:22] = shadow[j].vppn[18:9];
            if (shadow[j].ps == tlb_pkg::PS_4K) va[21:13] = shadow[j].vppn[8:0];
            if (r[26:25] == 2'b00) asid = ~asid;
        end
    endtask

    initial begin
        tlb_pkg::tlb_entry_t ent;
        logic [31:0] va;
        logic [31:0] r;
        logic [9:0] asid;

        rst = 1'b1;
        ad_mode = 2'b00;
        set_lookup(0, 1'b0, '0, '0, 2'd0, tlb_pkg::MEM_FETCH);
        set_lookup(1, 1'b0, '0, '0, 2'd0, tlb_pkg::MEM_LOAD);
        we = 1'b0;
        fill_mode = 1'b0;
        w_index = '0;
        f_index = '0;
        w_ent = '0;
        w_ent.ps = tlb_pkg::PS_4K;
        r_index = '0;
        s_vppn = '0;
        s_asid = '0;
        check_mode = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "reset read";
        for (int i = 0; i < TLBNUM; i++) begin
            @(negedge clk);
            r_index = IDX_W'(i);
        end

        test_name = "write and read";
        for (int i = 0; i < TLBNUM; i++) begin
            write_entry(i, make_entry(i), i[0]);
        end
        for (int i = 0; i < TLBNUM; i++) begin
            @(negedge clk);
            r_index = IDX_W'(i);
        end

        test_name = "software search";
        check_mode = 1'b1;
        for (int i = 0; i < TLBNUM; i++) begin
            @(negedge clk);
            s_vppn = shadow[i].vppn;
            // odd entries use a foreign asid so only global ones still hit
            s_asid = i[0] ? ~shadow[i].asid : shadow[i].asid;
        end
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            r = next_random();
            s_vppn = {r[3:0], 6'(TLBNUM + k), r[12:4]};
            s_asid = r[22:13];
        end
        @(negedge clk);
        check_mode = 1'b0;

        test_name = "paged translation";
        for (int n = 0; n < N_RAND; n++) begin
            @(negedge clk);
            r = next_random();
            random_lookup(va, asid);
            set_lookup(0, r[2] | r[3], va, asid, r[1:0],
                       tlb_pkg::mem_type_t'(2'(r[11:8] % 4'd3)));
            random_lookup(va, asid);
            set_lookup(1, r[4] | r[5], va, asid, r[7:6],
                       tlb_pkg::mem_type_t'(2'(r[15:12] % 4'd3)));
        end
        idle(1);

        test_name = "exceptions";
        ent = make_entry(0);
        ent.ps = tlb_pkg::PS_4K;
        ent.g = 1'b0;
        ent.p0.v = 1'b0;
        ent.p1.v = 1'b1;
        ent.p1.d = 1'b0;
        ent.p1.plv = 2'd1;
        write_entry(0, ent, 1'b0);
        va = {ent.vppn, 13'h0000};
        single_lookup(0, {8'hff, 24'h0}, ent.asid, 2'd0, tlb_pkg::MEM_FETCH);
        single_lookup(0, va | 32'h24, ent.asid, 2'd0, tlb_pkg::MEM_FETCH);
        single_lookup(1, va, ent.asid, 2'd0, tlb_pkg::MEM_LOAD);
        single_lookup(1, va, ent.asid, 2'd0, tlb_pkg::MEM_STORE);
        // odd half is valid and clean with plv 1
        single_lookup(1, va | 32'h1000, ent.asid, 2'd2, tlb_pkg::MEM_LOAD);
        single_lookup(1, va | 32'h1000, ent.asid, 2'd1, tlb_pkg::MEM_STORE);
        single_lookup(0, va | 32'h1abc, ent.asid, 2'd1, tlb_pkg::MEM_FETCH);
        single_lookup(1, va | 32'h1000, ~ent.asid, 2'd0, tlb_pkg::MEM_LOAD);
        idle(1);

        test_name = "direct mode";
        for (int n = 0; n < 8; n++) begin
            @(negedge clk);
            r = next_random();
            ad_mode = {r[0], 1'b1};
            set_lookup(0, 1'b1, next_random(), r[10:1], r[12:11], tlb_pkg::MEM_FETCH);
            set_lookup(1, 1'b1, next_random(), r[22:13], r[24:23], tlb_pkg::MEM_STORE);
        end
        idle(1);
        ad_mode = 2'b00;

        test_name = "hold";
        @(negedge clk);
        // port 0 holds a result of the entry that is rewritten below
        r = next_random();
        va = {shadow[5].vppn, r[12:0]};
        set_lookup(0, 1'b1, va, shadow[5].asid, 2'd0, tlb_pkg::MEM_FETCH);
        random_lookup(va, asid);
        set_lookup(1, 1'b1, va, asid, 2'd3, tlb_pkg::MEM_LOAD);
        idle(3);
        write_entry(5, make_entry(5), 1'b1);
        idle(5);

        $display("%0d errors in %0d lookups", errors, strobes);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

/* tlb.f */
design/tlb_pkg.sv
design/tlb_hit_if.sv
design/tlb_storage.sv
design/tlb_match.sv
design/tlb_translate.sv
design/tlb.sv
bench/tlb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the TLB testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tlb_tb -f tlb.f -o tlb_sim

output=$(./obj_dir/tlb_sim)
echo "$output"

if grep -q "^Verification passed$" <<< "$output"; then
    exit 0
else
    exit 1
fi
